//--- Bender.yml
package:
  name: decodeStage

sources:
  - rtl/decodePkg.sv
  - rtl/controlDecoder.sv
  - rtl/registerFile.sv
  - rtl/decodeStage.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/decodeStageTb.sv

//--- decodeStage.f
+incdir+tb
rtl/decodePkg.sv
rtl/controlDecoder.sv
rtl/registerFile.sv
rtl/decodeStage.sv
tb/decodeStageTb.sv

//--- rtl/controlDecoder.sv
// Control decoder
// Turns the opcode, plus func for the register ALU groups,
// into the execute, memory and writeback control bundle

`timescale 1ns/1ps

module controlDecoder (
   input  decodePkg::opcode_t opcode,
   input  logic [1:0]         func,
   output decodePkg::ctrl_t   ctrl
);

   ////////////////////////////////////////
   // Opcode class flags
   ////////////////////////////////////////
   logic isHaltNop;
   logic isBranch;
   logic isImmAlu;
   logic isImmShift;
   logic isRegAlu;
   logic isRegShift;
   logic isCompare;
   logic isMem;

   // Raw ALU select before folding, per the three group scheme
   decodePkg::aluOp_t aluSel;

   // Halt and nop share the top four bits
   assign isHaltNop  = (opcode[4:1] == 4'b0000);
   assign isBranch   = (opcode[4:2] == 3'b011);
   // ADDI SUBI XORI ANDNI
   assign isImmAlu   = (opcode[4:2] == 3'b010);
   // ROLI SLLI RORI SRLI
   assign isImmShift = (opcode[4:2] == 3'b101);
   assign isRegAlu   = (opcode == decodePkg::OpArithR);
   assign isRegShift = (opcode == decodePkg::OpShiftR);
   // SEQ SLT SLE SCO
   assign isCompare  = (opcode[4:2] == 3'b111);
   // SLBI sits in the same quadrant but never touches memory
   assign isMem      = (opcode == decodePkg::OpSt) || (opcode == decodePkg::OpLd) ||
                       (opcode == decodePkg::OpStu);

   // Group select
   always_comb begin
      if (isRegAlu || isRegShift) begin
         aluSel = {opcode[0], func};
      end else if (isImmShift) begin
         aluSel = {1'b0, opcode[1:0]};
      end else if (isImmAlu) begin
         aluSel = {1'b1, opcode[1:0]};
      end else begin
         aluSel = decodePkg::AluAdd;
      end
   end

   ////////////////////////////////////////
   // Control bundle
   ////////////////////////////////////////
   always_comb begin
      // PC control
      ctrl.immSrc  = (opcode == decodePkg::OpJ) || (opcode == decodePkg::OpJal);
      ctrl.aluJump = (opcode == decodePkg::OpJr) || (opcode == decodePkg::OpJalr);

      // Memory control
      ctrl.memEnable = isMem;
      ctrl.memWrite  = (opcode == decodePkg::OpSt) || (opcode == decodePkg::OpStu);

      // No register result for these
      ctrl.regWrite = !(isHaltNop || isBranch || (opcode == decodePkg::OpJ) ||
                        (opcode == decodePkg::OpJr) || (opcode == decodePkg::OpSt));

      // Writeback source
      if ((opcode == decodePkg::OpLbi) || (opcode == decodePkg::OpSlbi)) begin
         ctrl.regSrc = decodePkg::RegSrcB;
      end else if (opcode == decodePkg::OpLd) begin
         ctrl.regSrc = decodePkg::RegSrcMem;
      end else if (isHaltNop || (opcode == decodePkg::OpJal) ||
                   (opcode == decodePkg::OpJalr)) begin
         ctrl.regSrc = decodePkg::RegSrcLink;
      end else begin
         ctrl.regSrc = decodePkg::RegSrcAlu;
      end

      // Subtract forms flip A, SUB is func 01
      ctrl.invA = (opcode == decodePkg::OpSubi) || (isRegAlu && (func == 2'b01));
      // ANDN forms and the compares flip B, ANDN is func 11
      ctrl.invB = (opcode == decodePkg::OpAndni) || (isRegAlu && (func == 2'b11)) ||
                  (isCompare && (opcode != decodePkg::OpSco));
      ctrl.carryIn = ctrl.invA || ctrl.invB;

      // B input source
      if (isRegAlu || isRegShift || isCompare) begin
         ctrl.bSrc = decodePkg::BSrcReg;
      end else if (isImmAlu || isImmShift || isMem) begin
         ctrl.bSrc = decodePkg::BSrcImm5;
      end else if (opcode == decodePkg::OpSlbi) begin
         ctrl.bSrc = decodePkg::BSrcSlbi;
      end else begin
         ctrl.bSrc = decodePkg::BSrcImm8;
      end

      // Branch condition straight from the opcode low bits
      ctrl.brType = isBranch ? {1'b1, opcode[1:0]} : 3'b000;

      // Fold the raw select, SUB rides on add and ANDN on and
      if (isHaltNop) begin
         ctrl.aluOp = '0;
      end else begin
         case (aluSel)
            3'b100, 3'b101: ctrl.aluOp = decodePkg::AluAdd;
            3'b110:         ctrl.aluOp = decodePkg::AluXor;
            3'b111:         ctrl.aluOp = decodePkg::AluAnd;
            default:        ctrl.aluOp = aluSel;
         endcase
      end

      // Overflow only matters for the signed arithmetic
      ctrl.signedOp = !(isHaltNop || (opcode == decodePkg::OpSco));
   end

   // A store must also enable memory
   always_comb begin
      memWriteNeedsEnable: assert final (!ctrl.memWrite || ctrl.memEnable)
         else $error("memWrite without memEnable for opcode %05b", opcode);
   end

endmodule

//--- rtl/decodePkg.sv
// Decode stage shared definitions
// Field widths, opcode map, ALU and source encodings,
// control bundle, ID/EX bundle and writeback port bundle

package decodePkg;

   ////////////////////////////////////////
   // Plain field types
   ////////////////////////////////////////
   typedef logic [15:0] word_t;
   typedef logic [2:0]  regIdx_t;
   typedef logic [4:0]  opcode_t;
   typedef logic [2:0]  aluOp_t;
   typedef logic [1:0]  bSrc_t;
   typedef logic [1:0]  regSrc_t;
   // Top bit flags a branch, low bits pick the condition
   typedef logic [2:0]  brType_t;

   // Register file depth and the link register
   localparam int      NumRegs = 8;
   localparam regIdx_t LinkReg = 3'd7;

   ////////////////////////////////////////
   // Opcode map, instruction bits 15 to 11
   ////////////////////////////////////////
   localparam opcode_t OpHalt   = 5'b00000;
   localparam opcode_t OpNop    = 5'b00001;
   localparam opcode_t OpJ      = 5'b00100;
   localparam opcode_t OpJr     = 5'b00101;
   localparam opcode_t OpJal    = 5'b00110;
   localparam opcode_t OpJalr   = 5'b00111;
   localparam opcode_t OpAddi   = 5'b01000;
   localparam opcode_t OpSubi   = 5'b01001;
   localparam opcode_t OpXori   = 5'b01010;
   localparam opcode_t OpAndni  = 5'b01011;
   localparam opcode_t OpBeqz   = 5'b01100;
   localparam opcode_t OpBnez   = 5'b01101;
   localparam opcode_t OpBltz   = 5'b01110;
   localparam opcode_t OpBgez   = 5'b01111;
   localparam opcode_t OpSt     = 5'b10000;
   localparam opcode_t OpLd     = 5'b10001;
   localparam opcode_t OpSlbi   = 5'b10010;
   localparam opcode_t OpStu    = 5'b10011;
   localparam opcode_t OpLbi    = 5'b11000;
   localparam opcode_t OpBtr    = 5'b11001;
   // Register shifts and register arithmetic, refined by func
   localparam opcode_t OpShiftR = 5'b11010;
   localparam opcode_t OpArithR = 5'b11011;
   localparam opcode_t OpSeq    = 5'b11100;
   localparam opcode_t OpSlt    = 5'b11101;
   localparam opcode_t OpSle    = 5'b11110;
   localparam opcode_t OpSco    = 5'b11111;

   // ALU operation select
   localparam aluOp_t AluRol = 3'b000;
   localparam aluOp_t AluSll = 3'b001;
   localparam aluOp_t AluRor = 3'b010;
   localparam aluOp_t AluSrl = 3'b011;
   localparam aluOp_t AluAdd = 3'b100;
   localparam aluOp_t AluAnd = 3'b101;
   localparam aluOp_t AluXor = 3'b111;

   // B input and writeback sources
   localparam bSrc_t   BSrcReg    = 2'd0;
   localparam bSrc_t   BSrcImm5   = 2'd1;
   localparam bSrc_t   BSrcImm8   = 2'd2;
   localparam bSrc_t   BSrcSlbi   = 2'd3;
   localparam regSrc_t RegSrcLink = 2'd0;
   localparam regSrc_t RegSrcMem  = 2'd1;
   localparam regSrc_t RegSrcAlu  = 2'd2;
   localparam regSrc_t RegSrcB    = 2'd3;

   ////////////////////////////////////////
   // Bundles
   ////////////////////////////////////////
   typedef struct packed {
      logic    immSrc;
      logic    aluJump;
      logic    invA;
      logic    invB;
      logic    carryIn;
      logic    signedOp;
      brType_t brType;
      aluOp_t  aluOp;
      bSrc_t   bSrc;
      regSrc_t regSrc;
      logic    regWrite;
      logic    memWrite;
      logic    memEnable;
   } ctrl_t;

   typedef struct packed {
      logic    valid;
      word_t   pc;
      word_t   instruction;
      ctrl_t   ctrl;
      word_t   regA;
      word_t   regB;
      word_t   imm5;
      word_t   imm8;
      word_t   imm11;
      word_t   slbiValue;
      regIdx_t destReg;
   } idEx_t;

   // Writeback port into the register file
   typedef struct packed {
      logic    valid;
      regIdx_t regIdx;
      word_t   data;
   } wb_t;

endpackage

//--- rtl/decodeStage.sv
// Instruction decode stage
// Decodes the control bundle, reads both operands, builds the
// immediates and the destination index, then registers the
// whole set into the ID/EX bundle one cycle later

`timescale 1ns/1ps

module decodeStage #(
   parameter bit BypassWrite = 1'b1
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             instrValid,
   input  decodePkg::word_t instruction,
   input  decodePkg::word_t pc,
   input  decodePkg::wb_t   wb,
   output decodePkg::idEx_t idEx
);

   ////////////////////////////////////////
   // Internal signals
   ////////////////////////////////////////
   decodePkg::opcode_t opcode;
   decodePkg::ctrl_t   ctrl;
   decodePkg::word_t   regA;
   decodePkg::word_t   regB;
   decodePkg::word_t   imm5;
   decodePkg::word_t   imm8;
   decodePkg::word_t   imm11;
   decodePkg::word_t   slbiValue;
   decodePkg::regIdx_t destReg;
   decodePkg::idEx_t   idExNext;

   // XORI and ANDNI take their immediates unsigned
   logic zeroExt;

   assign opcode = instruction[15:11];

   ////////////////////////////////////////
   // Control and operands
   ////////////////////////////////////////
   controlDecoder ctrlDec (
      .opcode (opcode),
      .func   (instruction[1:0]),
      .ctrl   (ctrl)
   );

   // Rs in bits 10 to 8, Rt in bits 7 to 5
   registerFile #(
      .BypassWrite (BypassWrite)
   ) regFile (
      .clk       (clk),
      .reset     (reset),
      .readIdxA  (instruction[10:8]),
      .readIdxB  (instruction[7:5]),
      .wb        (wb),
      .readDataA (regA),
      .readDataB (regB)
   );

   ////////////////////////////////////////
   // Immediates
   ////////////////////////////////////////
   assign zeroExt = (opcode == decodePkg::OpXori) || (opcode == decodePkg::OpAndni);

   assign imm5 = zeroExt ? {11'h000, instruction[4:0]} :
                           {{11{instruction[4]}}, instruction[4:0]};
   assign imm8 = zeroExt ? {8'h00, instruction[7:0]} :
                           {{8{instruction[7]}}, instruction[7:0]};
   // Jump offsets are always signed
   assign imm11 = {{5{instruction[10]}}, instruction[10:0]};

   // Shift the old low byte up, new byte goes underneath
   assign slbiValue = {regA[7:0], instruction[7:0]};

   ////////////////////////////////////////
   // Destination register
   ////////////////////////////////////////
   always_comb begin
      if ((opcode == decodePkg::OpJal) || (opcode == decodePkg::OpJalr)) begin
         // Link always lands in R7
         destReg = decodePkg::LinkReg;
      end else if ((opcode == decodePkg::OpArithR) || (opcode == decodePkg::OpShiftR) ||
                   (opcode[4:2] == 3'b111)) begin
         // R format, Rd in bits 4 to 2
         destReg = instruction[4:2];
      end else if ((opcode[4:2] == 3'b010) || (opcode[4:2] == 3'b101) ||
                   (opcode == decodePkg::OpLd) || (opcode == decodePkg::OpBtr)) begin
         // Immediate ALU and shift forms, LD and BTR
         destReg = instruction[7:5];
      end else begin
         // LBI, SLBI, STU and everything that never writes
         destReg = instruction[10:8];
      end
   end

   ////////////////////////////////////////
   // ID/EX register
   ////////////////////////////////////////
   always_comb begin
      idExNext.valid       = instrValid;
      idExNext.pc          = pc;
      idExNext.instruction = instruction;
      idExNext.ctrl        = ctrl;
      idExNext.regA        = regA;
      idExNext.regB        = regB;
      idExNext.imm5        = imm5;
      idExNext.imm8        = imm8;
      idExNext.imm11       = imm11;
      idExNext.slbiValue   = slbiValue;
      idExNext.destReg     = destReg;
   end

   // Whole bundle clears so downstream sees zeros after reset
   always_ff @(posedge clk) begin
      if (reset) begin
         idEx <= '0;
      end else begin
         idEx <= idExNext;
      end
   end

   // Every valid output traces back to a strobe one edge earlier
   validFollowsStrobe: assert property (
      @(posedge clk) disable iff (reset)
      idEx.valid |-> $past(instrValid)
   ) else $error("idEx.valid without an instruction strobe on the previous edge");

endmodule

//--- rtl/registerFile.sv
// Register file
// Eight 16-bit registers, two combinational read ports,
// one write port from writeback, optional same-cycle bypass

`timescale 1ns/1ps

module registerFile #(
   parameter bit BypassWrite = 1'b1
) (
   input  logic               clk,
   input  logic               reset,
   input  decodePkg::regIdx_t readIdxA,
   input  decodePkg::regIdx_t readIdxB,
   input  decodePkg::wb_t     wb,
   output decodePkg::word_t   readDataA,
   output decodePkg::word_t   readDataB
);

   // Architectural registers
   decodePkg::word_t regs [decodePkg::NumRegs];

   // Same-cycle write hits on each read port
   logic bypassA;
   logic bypassB;

   ////////////////////////////////////////
   // Write port
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < decodePkg::NumRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.valid) begin
         regs[wb.regIdx] <= wb.data;
      end
   end

   ////////////////////////////////////////
   // Read ports
   ////////////////////////////////////////
   // Hit only when bypass is built in and the write targets that index
   assign bypassA = BypassWrite && wb.valid && (wb.regIdx == readIdxA);
   assign bypassB = BypassWrite && wb.valid && (wb.regIdx == readIdxB);

   assign readDataA = bypassA ? wb.data : regs[readIdxA];
   assign readDataB = bypassB ? wb.data : regs[readIdxB];

   // Writeback must carry clean data into the array
   wbDataKnown: assert property (
      @(posedge clk) disable iff (reset)
      wb.valid |-> !$isunknown(wb.data)
   ) else $error("writeback to R%0d with unknown data", wb.regIdx);

endmodule

//--- tb/decodeRefModel.svh
// Decode reference model
// Expected control bundle, immediates and destination index
// worked out from the instruction alone

`ifndef DECODE_REF_MODEL_SVH
`define DECODE_REF_MODEL_SVH

// ALU select inside the add/sub/xor/andn group
function automatic decodePkg::aluOp_t refArithOp(logic [1:0] sel);
   case (sel)
      2'b10:   return decodePkg::AluXor;
      2'b11:   return decodePkg::AluAnd;
      // SUB rides on the adder
      default: return decodePkg::AluAdd;
   endcase
endfunction

function automatic decodePkg::ctrl_t refCtrl(decodePkg::word_t instr);
   decodePkg::ctrl_t   c;
   decodePkg::opcode_t op;
   logic [1:0]         fn;
   logic               haltNop;
   logic               regReg;
   logic               mem;
   op = instr[15:11];
   fn = instr[1:0];
   haltNop = (op == decodePkg::OpHalt) || (op == decodePkg::OpNop);
   // Register ALU, register shift and the four compares
   regReg = (op == decodePkg::OpArithR) || (op == decodePkg::OpShiftR) || (op[4:2] == 3'b111);
   mem = (op == decodePkg::OpSt) || (op == decodePkg::OpLd) || (op == decodePkg::OpStu);
   c = '0;
   c.immSrc = (op == decodePkg::OpJ) || (op == decodePkg::OpJal);
   c.aluJump = (op == decodePkg::OpJr) || (op == decodePkg::OpJalr);
   c.memEnable = mem;
   c.memWrite = (op == decodePkg::OpSt) || (op == decodePkg::OpStu);
   c.regWrite = !(haltNop || (op == decodePkg::OpJ) || (op == decodePkg::OpJr) ||
                  (op[4:2] == 3'b011) || (op == decodePkg::OpSt));
   // Writeback source
   if ((op == decodePkg::OpLbi) || (op == decodePkg::OpSlbi))
      c.regSrc = 2'd3;
   else if (op == decodePkg::OpLd)
      c.regSrc = 2'd1;
   else if (haltNop || (op == decodePkg::OpJal) || (op == decodePkg::OpJalr))
      c.regSrc = 2'd0;
   else
      c.regSrc = 2'd2;
   c.invA = (op == decodePkg::OpSubi) || ((op == decodePkg::OpArithR) && (fn == 2'b01));
   c.invB = (op == decodePkg::OpAndni) || ((op == decodePkg::OpArithR) && (fn == 2'b11)) ||
            (op == decodePkg::OpSeq) || (op == decodePkg::OpSlt) || (op == decodePkg::OpSle);
   c.carryIn = c.invA || c.invB;
   // B input source
   if (regReg)
      c.bSrc = 2'd0;
   else if ((op[4:2] == 3'b010) || (op[4:2] == 3'b101) || mem)
      c.bSrc = 2'd1;
   else if (op == decodePkg::OpSlbi)
      c.bSrc = 2'd3;
   else
      c.bSrc = 2'd2;
   c.brType = (op[4:2] == 3'b011) ? {1'b1, op[1:0]} : 3'b000;
   // Three ALU groups, add elsewhere
   if (haltNop)
      c.aluOp = 3'b000;
   else if (op == decodePkg::OpShiftR)
      c.aluOp = {1'b0, fn};
   else if (op[4:2] == 3'b101)
      c.aluOp = {1'b0, op[1:0]};
   else if (op == decodePkg::OpArithR)
      c.aluOp = refArithOp(fn);
   else if (op[4:2] == 3'b010)
      c.aluOp = refArithOp(op[1:0]);
   else
      c.aluOp = decodePkg::AluAdd;
   c.signedOp = !(haltNop || (op == decodePkg::OpSco));
   return c;
endfunction

// Low bits of the instruction, widened with or without sign
function automatic decodePkg::word_t refImm(decodePkg::word_t instr, int bits, bit signExt);
   decodePkg::word_t mask;
   mask = (16'h1 << bits) - 16'h1;
   if (signExt && instr[bits-1])
      return instr | ~mask;
   return instr & mask;
endfunction

// XORI and ANDNI keep their short immediates unsigned
function automatic bit refSignExt(decodePkg::word_t instr);
   return !((instr[15:11] == decodePkg::OpXori) || (instr[15:11] == decodePkg::OpAndni));
endfunction

function automatic decodePkg::regIdx_t refDest(decodePkg::word_t instr);
   decodePkg::opcode_t op;
   op = instr[15:11];
   if ((op == decodePkg::OpJal) || (op == decodePkg::OpJalr))
      return 3'd7;
   if ((op == decodePkg::OpArithR) || (op == decodePkg::OpShiftR) || (op[4:2] == 3'b111))
      return instr[4:2];
   if ((op[4:2] == 3'b010) || (op[4:2] == 3'b101) || (op == decodePkg::OpLd) ||
       (op == decodePkg::OpBtr))
      return instr[7:5];
   return instr[10:8];
endfunction

`endif

//--- tb/decodeStageTb.sv
// Decode stage testbench
// Directed tests for reset, operand reads, write bypass, control
// decode, immediates and strobe timing against a reference model

`timescale 1ns/1ps

module decodeStageTb;

   `include "decodeRefModel.svh"

   // Strobes per test, the watchdog limit scales with them
   localparam int ResetStrobes  = 4;
   localparam int RegStrobes    = 72;
   localparam int BypassStrobes = 3;
   localparam int CtrlStrobes   = 128;
   localparam int ImmStrobes    = 64;
   localparam int PipeStrobes   = 13;
   localparam int TimeoutCycles = 16 + 8 * (ResetStrobes + RegStrobes + BypassStrobes +
                                            CtrlStrobes + ImmStrobes + PipeStrobes);

   logic             clk;
   logic             reset;
   logic             instrValid;
   decodePkg::word_t instruction;
   decodePkg::word_t pc;
   decodePkg::wb_t   wb;
   decodePkg::idEx_t idEx;

   // Mirror of the register file contents
   decodePkg::word_t shadow [8];
   int               cycleCount;
   int               errorCount;
   int               checkCount;
   int               failedTests;
   int               errorsAtStart;
   int unsigned      rndSeed;

   decodeStage #(
      .BypassWrite (1'b1)
   ) u_dut (
      .clk         (clk),
      .reset       (reset),
      .instrValid  (instrValid),
      .instruction (instruction),
      .pc          (pc),
      .wb          (wb),
      .idEx        (idEx)
   );

   always #2 clk = ~clk;

   // Watchdog
   always @(posedge clk) begin
      cycleCount = cycleCount + 1;
      if (cycleCount > TimeoutCycles) begin
         $display("timeout after %0d cycles, the tests did not finish", TimeoutCycles);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   ////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////
   task automatic checkWord(string name, decodePkg::word_t got, decodePkg::word_t exp);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("mismatch %s: expected 0x%04h, got 0x%04h", name, exp, got);
      end
   endtask

   task automatic checkCtrl(string name, decodePkg::ctrl_t got, decodePkg::ctrl_t exp);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("mismatch %s: expected 0x%05h, got 0x%05h", name, exp, got);
      end
   endtask

   task automatic checkRegIdx(string name, decodePkg::regIdx_t got, decodePkg::regIdx_t exp);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("mismatch %s: expected 0x%01h, got 0x%01h", name, exp, got);
      end
   endtask

   task automatic checkBit(string name, logic got, logic exp);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("mismatch %s: expected 0x%01h, got 0x%01h", name, exp, got);
      end
   endtask

   task automatic checkBundle(decodePkg::idEx_t exp);
      checkBit("idEx.valid", idEx.valid, exp.valid);
      checkWord("idEx.pc", idEx.pc, exp.pc);
      checkWord("idEx.instruction", idEx.instruction, exp.instruction);
      checkCtrl("idEx.ctrl", idEx.ctrl, exp.ctrl);
      checkWord("idEx.regA", idEx.regA, exp.regA);
      checkWord("idEx.regB", idEx.regB, exp.regB);
      checkWord("idEx.imm5", idEx.imm5, exp.imm5);
      checkWord("idEx.imm8", idEx.imm8, exp.imm8);
      checkWord("idEx.imm11", idEx.imm11, exp.imm11);
      checkWord("idEx.slbiValue", idEx.slbiValue, exp.slbiValue);
      checkRegIdx("idEx.destReg", idEx.destReg, exp.destReg);
   endtask

   ////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////
   // Operands come from the mirror, SLBI packs Rs low byte over the immediate byte
   function automatic decodePkg::idEx_t expectBundle(decodePkg::word_t instr,
                                                     decodePkg::word_t pcVal);
      decodePkg::idEx_t e;
      e.valid = 1'b1;
      e.pc = pcVal;
      e.instruction = instr;
      e.ctrl = refCtrl(instr);
      e.regA = shadow[instr[10:8]];
      e.regB = shadow[instr[7:5]];
      e.imm5 = refImm(instr, 5, refSignExt(instr));
      e.imm8 = refImm(instr, 8, refSignExt(instr));
      e.imm11 = refImm(instr, 11, 1'b1);
      e.slbiValue = {e.regA[7:0], instr[7:0]};
      e.destReg = refDest(instr);
      return e;
   endfunction

   // One strobe, result checked one edge later
   task automatic decodeCheck(decodePkg::word_t instr, decodePkg::word_t pcVal);
      decodePkg::idEx_t exp;
      exp = expectBundle(instr, pcVal);
      instrValid = 1'b1;
      instruction = instr;
      pc = pcVal;
      @(posedge clk);
      #1;
      instrValid = 1'b0;
      checkBundle(exp);
   endtask

   task automatic writeReg(decodePkg::regIdx_t idx, decodePkg::word_t data);
      wb.valid = 1'b1;
      wb.regIdx = idx;
      wb.data = data;
      @(posedge clk);
      #1;
      wb.valid = 1'b0;
      shadow[idx] = data;
   endtask

   task automatic reportTest(string name);
      if (errorCount == errorsAtStart) begin
         $display("%-14s ok", name);
      end else begin
         failedTests++;
         $display("%-14s failed with %0d mismatches", name, errorCount - errorsAtStart);
      end
      errorsAtStart = errorCount;
   endtask

   // Opcodes with special immediate or destination handling
   function automatic decodePkg::opcode_t focusOp(int k);
      case (k % 6)
         0:       return decodePkg::OpXori;
         1:       return decodePkg::OpAndni;
         2:       return decodePkg::OpJal;
         3:       return decodePkg::OpJalr;
         4:       return decodePkg::OpSlbi;
         default: return decodePkg::OpAddi;
      endcase
   endfunction

   ////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////
   task automatic resetState();
      checkBundle('0);
      for (int i = 0; i < ResetStrobes; i++) begin
         decodeCheck({decodePkg::OpArithR, 11'($urandom)}, 16'($urandom));
      end
      reportTest("resetState");
   endtask

   task automatic registerReads();
      for (int r = 0; r < 8; r++) begin
         writeReg(3'(r), 16'($urandom));
      end
      // Every Rs and Rt pair
      for (int a = 0; a < 8; a++) begin
         for (int b = 0; b < 8; b++) begin
            decodeCheck({decodePkg::OpArithR, 3'(a), 3'(b), 5'($urandom)}, 16'($urandom));
         end
      end
      reportTest("registerReads");
   endtask

   task automatic writeBypass();
      // Same edge write to Rs, then to Rt
      wb.valid = 1'b1;
      wb.regIdx = 3'd3;
      wb.data = 16'($urandom);
      shadow[3] = wb.data;
      decodeCheck({decodePkg::OpArithR, 3'd3, 3'd5, 5'd0}, 16'h0040);
      wb.regIdx = 3'd6;
      wb.data = 16'($urandom);
      shadow[6] = wb.data;
      decodeCheck({decodePkg::OpArithR, 3'd1, 3'd6, 5'd0}, 16'h0042);
      wb.valid = 1'b0;
      // Both writes must also have landed in the array
      decodeCheck({decodePkg::OpArithR, 3'd3, 3'd6, 5'd0}, 16'h0044);
      reportTest("writeBypass");
   endtask

   task automatic controlTable();
      for (int op = 0; op < 32; op++) begin
         for (int fn = 0; fn < 4; fn++) begin
            decodeCheck({5'(op), 9'($urandom), 2'(fn)}, 16'($urandom));
         end
      end
      reportTest("controlTable");
   endtask

   task automatic immediates();
      decodePkg::word_t instr;
      for (int i = 0; i < ImmStrobes; i++) begin
         instr = 16'($urandom);
         if (i % 2 == 0) begin
            instr[15:11] = focusOp(i / 2);
         end
         decodeCheck(instr, 16'($urandom));
      end
      reportTest("immediates");
   endtask

   task automatic strobeTiming();
      decodePkg::idEx_t exp;
      logic             strobe;
      // Eight back to back, then one strobe every third cycle
      for (int c = 0; c < 24; c++) begin
         strobe = (c < 8) || (c % 3 == 0);
         instruction = 16'($urandom);
         pc = 16'($urandom);
         exp = expectBundle(instruction, pc);
         instrValid = strobe;
         @(posedge clk);
         #1;
         if (strobe) begin
            checkBundle(exp);
         end else begin
            checkBit("idEx.valid", idEx.valid, 1'b0);
         end
      end
      instrValid = 1'b0;
      @(posedge clk);
      #1;
      checkBit("idEx.valid", idEx.valid, 1'b0);
      reportTest("strobeTiming");
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////
   initial begin
      rndSeed = 32'h2307ccb4;
      void'($urandom(rndSeed));
      clk = 1'b0;
      reset = 1'b1;
      instrValid = 1'b0;
      instruction = '0;
      pc = '0;
      wb = '0;
      cycleCount = 0;
      errorCount = 0;
      checkCount = 0;
      failedTests = 0;
      errorsAtStart = 0;
      for (int i = 0; i < 8; i++) begin
         shadow[i] = '0;
      end
      repeat (16) @(posedge clk);
      #1;
      reset = 1'b0;
      resetState();
      registerReads();
      writeBypass();
      controlTable();
      immediates();
      strobeTiming();
      $display("tests 6, failed tests %0d, checks %0d, mismatches %0d",
               failedTests, checkCount, errorCount);
      if (errorCount == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule
